/* source/allocPkg.sv */
package allocPkg;

	localparam int ENTRIES = 16;
	localparam int IDX_W = 4; // Slot index.
	localparam int CNT_W = 5; // Counts 0 to 16.
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// Encoded by byte offset.
	typedef enum logic [ADDR_W-1:0] {
		REG_ALLOC = 8'h00,
		REG_FREE = 8'h04,
		REG_OCCUPIED = 8'h08,
		REG_COUNT = 8'h0C,
		REG_RANK = 8'h10,
		REG_NONE = 8'hFF
	} regSel;

	typedef enum logic {
		IDLE,
		ACCESS
	} ctrlState;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic [DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp;

	// One enable at most per cycle.
	typedef struct packed {
		logic allocEn;
		logic freeEn;
		logic [IDX_W-1:0] idx;
	} tableCmd;

endpackage

/* source/allocCtrl.sv */
`timescale 1ns/1ps

module allocCtrl (
	input  logic clk_i,
	input  logic arstN_i,
	input  allocPkg::apbReq apbReq_i,
	output allocPkg::apbRsp apbRsp_o,
	output allocPkg::tableCmd cmd_o,
	input  logic [allocPkg::ENTRIES-1:0] occupied_i,
	input  logic [allocPkg::IDX_W-1:0] freeIdx_i,
	input  logic full_i,
	output logic setQuery_o,
	output logic [allocPkg::IDX_W-1:0] queryIdx_o,
	input  logic [allocPkg::CNT_W-1:0] rank_i,
	input  logic [allocPkg::CNT_W-1:0] total_i
);
	import allocPkg::*;

	ctrlState state;
	ctrlState stateNext;
	regSel sel;
	logic setup;
	logic [IDX_W-1:0] wrIdx;
	apbRsp rspNext;
	tableCmd cmdNext;
	logic setQueryNext;

	function automatic regSel decodeAddr(input logic [ADDR_W-1:0] addr);
		regSel res;
		case (addr)
		REG_ALLOC, REG_FREE, REG_OCCUPIED, REG_COUNT, REG_RANK: res = regSel'(addr);
		default: res = REG_NONE;
		endcase
		return res;
	endfunction

	assign setup = (state == IDLE) && apbReq_i.psel && !apbReq_i.penable;
	assign sel = decodeAddr(apbReq_i.paddr);
	assign wrIdx = apbReq_i.pwdata[IDX_W-1:0];

	always_comb begin
		case (state)
		IDLE: stateNext = setup ? ACCESS : IDLE;
		default: stateNext = IDLE; // Access always lasts one cycle.
		endcase
	end

	// Response and command are decided in the setup cycle.
	always_comb begin
		rspNext = '0;
		cmdNext = '0;
		setQueryNext = 1'b0;
		rspNext.pready = 1'b1;
		cmdNext.idx = apbReq_i.pwrite ? wrIdx : freeIdx_i;
		case (sel)
		REG_ALLOC: begin
			if (apbReq_i.pwrite) begin
				rspNext.pslverr = 1'b1;
			end else if (full_i) begin
				rspNext.pslverr = 1'b1;
				rspNext.prdata = DATA_W'(ENTRIES); // Reads as 0x10.
			end else begin
				rspNext.prdata = DATA_W'(freeIdx_i);
				cmdNext.allocEn = 1'b1;
			end
		end
		REG_FREE: begin
			if (!apbReq_i.pwrite || !occupied_i[wrIdx]) begin
				rspNext.pslverr = 1'b1; // Double free too.
			end else begin
				cmdNext.freeEn = 1'b1;
			end
		end
		REG_OCCUPIED: begin
			if (apbReq_i.pwrite) begin
				rspNext.pslverr = 1'b1;
			end else begin
				rspNext.prdata = DATA_W'(occupied_i);
			end
		end
		REG_COUNT: begin
			if (apbReq_i.pwrite) begin
				rspNext.pslverr = 1'b1;
			end else begin
				rspNext.prdata = DATA_W'(total_i);
			end
		end
		REG_RANK: begin
			if (apbReq_i.pwrite) begin
				setQueryNext = 1'b1;
			end else begin
				rspNext.prdata = DATA_W'(rank_i);
			end
		end
		default: rspNext.pslverr = 1'b1;
		endcase
	end

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			state <= IDLE;
			apbRsp_o <= '0;
			cmd_o <= '0;
			setQuery_o <= 1'b0;
		end else begin
			state <= stateNext;
			// Held for the access cycle only.
			apbRsp_o <= setup ? rspNext : '0;
			cmd_o <= setup ? cmdNext : '0;
			setQuery_o <= setup && setQueryNext;
		end
	end

	always_ff @(posedge clk_i) begin
		if (setup) begin
			queryIdx_o <= wrIdx;
		end
	end

endmodule

/* source/entryTable.sv */
`timescale 1ns/1ps

module entryTable (
	input  logic clk_i,
	input  logic arstN_i,
	input  allocPkg::tableCmd cmd_i,
	output logic [allocPkg::ENTRIES-1:0] occupied_o
);
	import allocPkg::*;

	logic [ENTRIES-1:0] oneHot;

	always_comb begin
		case (cmd_i.idx)
		4'h0: oneHot = 16'h0001;
		4'h1: oneHot = 16'h0002;
		4'h2: oneHot = 16'h0004;
		4'h3: oneHot = 16'h0008;
		4'h4: oneHot = 16'h0010;
		4'h5: oneHot = 16'h0020;
		4'h6: oneHot = 16'h0040;
		4'h7: oneHot = 16'h0080;
		4'h8: oneHot = 16'h0100;
		4'h9: oneHot = 16'h0200;
		4'ha: oneHot = 16'h0400;
		4'hb: oneHot = 16'h0800;
		4'hc: oneHot = 16'h1000;
		4'hd: oneHot = 16'h2000;
		4'he: oneHot = 16'h4000;
		4'hf: oneHot = 16'h8000;
		endcase
	end

	// Command is already checked by the controller.
	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			occupied_o <= '0;
		end else if (cmd_i.allocEn) begin
			occupied_o <= occupied_o | oneHot;
		end else if (cmd_i.freeEn) begin
			occupied_o <= occupied_o & ~oneHot;
		end
	end

endmodule

/* source/freePicker.sv */
`timescale 1ns/1ps

module freePicker (
	input  logic [allocPkg::ENTRIES-1:0] occupied_i,
	output logic [allocPkg::IDX_W-1:0] freeIdx_o,
	output logic full_o
);
	import allocPkg::*;

	logic [ENTRIES-1:0] freeVec;
	logic [IDX_W-2:0] lowIdx;
	logic [IDX_W-2:0] highIdx;
	logic lowAny;

	// Lowest set bit wins, all-zero gives 7.
	function automatic logic [IDX_W-2:0] prEnc8(input logic [ENTRIES/2-1:0] v);
		logic [IDX_W-2:0] res;
		if (v[0]) begin
			res = 3'b000;
		end else if (v[1]) begin
			res = 3'b001;
		end else if (v[2]) begin
			res = 3'b010;
		end else if (v[3]) begin
			res = 3'b011;
		end else if (v[4]) begin
			res = 3'b100;
		end else if (v[5]) begin
			res = 3'b101;
		end else if (v[6]) begin
			res = 3'b110;
		end else begin
			res = 3'b111;
		end
		return res;
	endfunction

	assign freeVec = ~occupied_i;

	assign lowIdx = prEnc8(freeVec[ENTRIES/2-1:0]);
	assign highIdx = prEnc8(freeVec[ENTRIES-1:ENTRIES/2]);
	assign lowAny = |freeVec[ENTRIES/2-1:0];

	assign freeIdx_o = {~lowAny, lowAny ? lowIdx : highIdx};
	assign full_o = ~|freeVec; // Index is meaningless when full.

endmodule

/* source/rankCounter.sv */
`timescale 1ns/1ps

module rankCounter (
	input  logic clk_i,
	input  logic arstN_i,
	input  logic [allocPkg::ENTRIES-1:0] occupied_i,
	input  logic setQuery_i,
	input  logic [allocPkg::IDX_W-1:0] queryIdx_i,
	output logic [allocPkg::CNT_W-1:0] rank_o,
	output logic [allocPkg::CNT_W-1:0] total_o
);
	import allocPkg::*;

	logic [IDX_W-1:0] queryReg;
	logic [3:0] mask4;
	logic [7:0] mask8;
	logic [ENTRIES-1:0] mask16;
	logic [ENTRIES-1:0] masked;
	logic [ENTRIES-1:0][CNT_W-1:0] maskedPfx;
	logic [ENTRIES-1:0][CNT_W-1:0] occPfx;

	// Entry i counts the set bits below position i.
	function automatic logic [ENTRIES-1:0][CNT_W-1:0] prefixCount(input logic [ENTRIES-1:0] v);
		logic [ENTRIES-1:0][CNT_W-1:0] pc;
		logic [CNT_W-1:0] run;
		run = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			pc[i] = run;
			run = run + CNT_W'(v[i]);
		end
		return pc;
	endfunction

	always_ff @(posedge clk_i or negedge arstN_i) begin
		if (!arstN_i) begin
			queryReg <= '0;
		end else if (setQuery_i) begin
			queryReg <= queryIdx_i;
		end
	end

	// Bit i set when i is below the query.
	assign mask4[0] = queryReg[1] | queryReg[0];
	assign mask4[1] = queryReg[1];
	assign mask4[2] = queryReg[1] & queryReg[0];
	assign mask4[3] = 1'b0;
	assign mask8 = {mask4 & {4{queryReg[2]}}, mask4 | {4{queryReg[2]}}};
	assign mask16 = {mask8 & {8{queryReg[3]}}, mask8 | {8{queryReg[3]}}};

	assign masked = mask16 & occupied_i;

	assign maskedPfx = prefixCount(masked);
	assign occPfx = prefixCount(occupied_i);

	// Last prefix plus the top bit is the full count.
	assign rank_o = maskedPfx[ENTRIES-1] + CNT_W'(masked[ENTRIES-1]);
	assign total_o = occPfx[ENTRIES-1] + CNT_W'(occupied_i[ENTRIES-1]);

endmodule

/* source/entryAllocTop.sv */
`timescale 1ns/1ps

module entryAllocTop (
	input  logic clk_i,
	input  logic arstN_i,
	input  allocPkg::apbReq apbReq_i,
	output allocPkg::apbRsp apbRsp_o
);
	import allocPkg::*;

	tableCmd cmd;
	logic [ENTRIES-1:0] occupied;
	logic [IDX_W-1:0] freeIdx;
	logic full;
	logic setQuery;
	logic [IDX_W-1:0] queryIdx;
	logic [CNT_W-1:0] rank;
	logic [CNT_W-1:0] total;

	// Only bus slave.
	allocCtrl allocCtrl_i (
		.clk_i      (clk_i),
		.arstN_i    (arstN_i),
		.apbReq_i   (apbReq_i),
		.apbRsp_o   (apbRsp_o),
		.cmd_o      (cmd),
		.occupied_i (occupied),
		.freeIdx_i  (freeIdx),
		.full_i     (full),
		.setQuery_o (setQuery),
		.queryIdx_o (queryIdx),
		.rank_i     (rank),
		.total_i    (total)
	);

	entryTable entryTable_i (
		.clk_i      (clk_i),
		.arstN_i    (arstN_i),
		.cmd_i      (cmd),
		.occupied_o (occupied)
	);

	freePicker freePicker_i (
		.occupied_i (occupied),
		.freeIdx_o  (freeIdx),
		.full_o     (full)
	);

	rankCounter rankCounter_i (
		.clk_i      (clk_i),
		.arstN_i    (arstN_i),
		.occupied_i (occupied),
		.setQuery_i (setQuery),
		.queryIdx_i (queryIdx),
		.rank_o     (rank),
		.total_o    (total)
	);

endmodule

/* dv/entryAllocTb.sv */
`timescale 1ns/1ps

module entryAllocTb;
	import allocPkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_STEPS = 40;
	localparam int PATTERNS = 8;
	localparam int QUERIES = 8;
	// Worst-case transfer count of all five tests.
	localparam int XFER_BOUND = 24 + RANDOM_STEPS * 6 + 9 + PATTERNS * (34 + 2 * QUERIES);
	localparam int CYCLE_LIMIT = RESET_CYCLES + 2 * 3 * XFER_BOUND; // Twice the need.

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic err;
		logic chkData;
	} xferRes;

	logic clk;
	logic arstN;
	apbReq req;
	apbRsp rsp;

	// Reference model state.
	logic [ENTRIES-1:0] refOcc;
	logic [IDX_W-1:0] refQuery;

	xferRes expQ[$];
	apbRsp obsQ[$];
	logic [ADDR_W-1:0] addrQ[$];

	integer seed;
	int checkCount;
	int errorCount;
	int cycles;

	entryAllocTop entryAllocTop_i (
		.clk_i    (clk),
		.arstN_i  (arstN),
		.apbReq_i (req),
		.apbRsp_o (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [CNT_W-1:0] lowestFree(input logic [ENTRIES-1:0] vec);
		logic [CNT_W-1:0] res;
		res = CNT_W'(ENTRIES); // 0x10 when full.
		for (int i = ENTRIES - 1; i >= 0; i--) begin
			if (!vec[i]) begin
				res = CNT_W'(i);
			end
		end
		return res;
	endfunction

	function automatic logic [CNT_W-1:0] countBelow(input logic [ENTRIES-1:0] vec,
			input int limit);
		logic [CNT_W-1:0] cnt;
		cnt = '0;
		for (int i = 0; i < limit; i++) begin
			cnt = cnt + CNT_W'(vec[i]);
		end
		return cnt;
	endfunction

	// Wraps around from start. Bit 4 set when none found.
	function automatic logic [CNT_W-1:0] pickSlot(input logic [ENTRIES-1:0] vec,
			input logic want, input logic [IDX_W-1:0] start);
		logic [IDX_W-1:0] idx;
		for (int n = 0; n < ENTRIES; n++) begin
			idx = start + IDX_W'(n);
			if (vec[idx] == want) begin
				return {1'b0, idx};
			end
		end
		return CNT_W'(ENTRIES);
	endfunction

	function automatic xferRes expectResult(input logic write, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic [ENTRIES-1:0] vec,
			input logic [IDX_W-1:0] query);
		xferRes res;
		res.data = '0;
		res.err = 1'b0;
		case (addr)
		REG_ALLOC: begin
			if (write) begin
				res.err = 1'b1;
			end else begin
				res.data = DATA_W'(lowestFree(vec));
				res.err = &vec;
			end
		end
		REG_FREE: res.err = write ? !vec[wdata[IDX_W-1:0]] : 1'b1;
		REG_OCCUPIED: begin
			res.err = write;
			res.data = write ? '0 : DATA_W'(vec);
		end
		REG_COUNT: begin
			res.err = write;
			res.data = write ? '0 : DATA_W'(countBelow(vec, ENTRIES));
		end
		REG_RANK: res.data = write ? '0 : DATA_W'(countBelow(vec, int'(query)));
		default: res.err = 1'b1;
		endcase
		res.chkData = !write || res.err; // Errors always read as data.
		return res;
	endfunction

	task automatic updateModel(input logic write, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		logic [CNT_W-1:0] slot;
		slot = lowestFree(refOcc);
		if (!write && addr == REG_ALLOC) begin
			refOcc[slot[IDX_W-1:0]] = 1'b1;
		end else if (write && addr == REG_FREE) begin
			refOcc[wdata[IDX_W-1:0]] = 1'b0;
		end else if (write && addr == REG_RANK) begin
			refQuery = wdata[IDX_W-1:0];
		end
	endtask

	// Setup, access, then one idle cycle.
	task automatic xfer(input logic write, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		xferRes exp;
		exp = expectResult(write, addr, wdata, refOcc, refQuery);
		@(negedge clk);
		req.psel = 1'b1;
		req.penable = 1'b0;
		req.pwrite = write;
		req.paddr = addr;
		req.pwdata = wdata;
		@(negedge clk);
		req.penable = 1'b1;
		expQ.push_back(exp);
		obsQ.push_back(rsp);
		addrQ.push_back(addr);
		if (!exp.err) begin
			updateModel(write, addr, wdata);
		end
		@(negedge clk);
		req = '0;
	endtask

	task automatic readReg(input logic [ADDR_W-1:0] addr);
		xfer(1'b0, addr, '0);
	endtask

	task automatic writeReg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		xfer(1'b1, addr, data);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errorCount == errBefore) begin
			$display("Test %s finished with no errors", name);
		end else begin
			$display("Test %s finished with %0d errors", name, errorCount - errBefore);
		end
	endtask

	task automatic testResetFill();
		int errBefore;
		errBefore = errorCount;
		checkCount++;
		if (rsp !== '0) begin
			$display("Fail apbRsp_o after reset: expected 0x%09h, got 0x%09h", 34'h0, rsp);
			errorCount++;
		end
		readReg(REG_OCCUPIED);
		readReg(REG_COUNT);
		repeat (ENTRIES) begin
			readReg(REG_ALLOC); // Indices 0 to 15 in order.
		end
		readReg(REG_OCCUPIED);
		reportTest("resetFill", errBefore);
	endtask

	task automatic testFullAlloc();
		int errBefore;
		errBefore = errorCount;
		readReg(REG_ALLOC);
		readReg(REG_OCCUPIED);
		readReg(REG_COUNT);
		reportTest("fullAlloc", errBefore);
	endtask

	task automatic testRandomFreeAlloc();
		int errBefore;
		int nFree;
		int nAlloc;
		logic [31:0] r;
		logic [CNT_W-1:0] slot;
		errBefore = errorCount;
		for (int step = 0; step < RANDOM_STEPS; step++) begin
			r = $random(seed);
			nFree = 1 + int'(r[4]);
			nAlloc = 1 + int'(r[5]);
			repeat (nFree) begin
				r = $random(seed);
				slot = pickSlot(refOcc, 1'b1, r[IDX_W-1:0]);
				if (!slot[IDX_W]) begin
					// Upper data bits are don't care.
					writeReg(REG_FREE, {r[DATA_W-1:IDX_W], slot[IDX_W-1:0]});
				end
			end
			repeat (nAlloc) begin
				readReg(REG_ALLOC);
			end
			readReg(REG_OCCUPIED);
			readReg(REG_COUNT);
		end
		reportTest("randomFreeAlloc", errBefore);
	endtask

	task automatic testErrorAccess();
		int errBefore;
		logic [CNT_W-1:0] slot;
		errBefore = errorCount;
		slot = pickSlot(refOcc, 1'b0, '0);
		if (slot[IDX_W]) begin
			writeReg(REG_FREE, 32'h5);
			slot = CNT_W'(5);
		end
		writeReg(REG_FREE, DATA_W'(slot[IDX_W-1:0])); // Double free.
		readReg(REG_OCCUPIED);
		writeReg(REG_ALLOC, 32'h3);
		readReg(REG_OCCUPIED);
		readReg(REG_FREE);
		readReg(8'h20);
		writeReg(8'h20, 32'h1);
		readReg(REG_OCCUPIED);
		reportTest("errorAccess", errBefore);
	endtask

	task automatic testRankQuery();
		int errBefore;
		logic [31:0] r;
		logic [ENTRIES-1:0] target;
		errBefore = errorCount;
		for (int p = 0; p < PATTERNS; p++) begin
			r = $random(seed);
			target = r[ENTRIES-1:0];
			while (!(&refOcc)) begin
				readReg(REG_ALLOC);
			end
			for (int i = 0; i < ENTRIES; i++) begin
				if (!target[i]) begin
					writeReg(REG_FREE, DATA_W'(i));
				end
			end
			readReg(REG_OCCUPIED);
			readReg(REG_COUNT);
			repeat (QUERIES) begin
				r = $random(seed);
				writeReg(REG_RANK, r);
				readReg(REG_RANK);
			end
		end
		reportTest("rankQuery", errBefore);
	endtask

	// Compares each observed access cycle with its expected result.
	initial begin : compareProc
		xferRes exp;
		apbRsp obs;
		logic [ADDR_W-1:0] addr;
		forever begin
			@(posedge clk);
			while (obsQ.size() > 0) begin
				exp = expQ.pop_front();
				obs = obsQ.pop_front();
				addr = addrQ.pop_front();
				checkCount++;
				if (obs.pready !== 1'b1) begin
					$display("Fail pready at address 0x%02h: expected 0x1, got 0x%0h",
						addr, obs.pready);
					errorCount++;
				end
				if (obs.pslverr !== exp.err) begin
					$display("Fail pslverr at address 0x%02h: expected 0x%0h, got 0x%0h",
						addr, exp.err, obs.pslverr);
					errorCount++;
				end
				if (exp.chkData && obs.prdata !== exp.data) begin
					$display("Fail prdata at address 0x%02h: expected 0x%08h, got 0x%08h",
						addr, exp.data, obs.prdata);
					errorCount++;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Checks failed");
		$finish;
	end

	initial begin
		req = '0;
		arstN = 1'b0;
		refOcc = '0;
		refQuery = '0;
		checkCount = 0;
		errorCount = 0;
		seed = 32'h8e69a64a;
		repeat (RESET_CYCLES) @(negedge clk);
		arstN = 1'b1;
		testResetFill();
		testFullAlloc();
		testRandomFreeAlloc();
		testErrorAccess();
		testRankQuery();
		@(negedge clk);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* sources.f */
source/allocPkg.sv
source/allocCtrl.sv
source/entryTable.sv
source/freePicker.sv
source/rankCounter.sv
source/entryAllocTop.sv
dv/entryAllocTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= entryAllocTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --timescale 1ns/1ps
PASS_MSG ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
